//--- me_ctrl_pkg.sv
`default_nettype none

package me_ctrl_pkg;

    localparam int ROW_W = 2;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_LAND,
        ST_CALC
    } fetch_state_t;

endpackage

`default_nettype wire

//--- me_cur_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module me_cur_buffer (
    input  wire                      clk,
    input  wire                      rst_i,
    me_load_if.sink                  load,
    output me_geom_pkg::cur_block_t  cur_blk_o
);

    // One 4-pixel row is written per load cycle, at the tagged row.
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            cur_blk_o <= '0;
        end
        else if (load.load_valid)
        begin
            cur_blk_o[load.row] <= load.cur_row;
        end
    end

endmodule

`default_nettype wire

//--- me_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module me_fetch_ctrl (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             start_i,
    input  wire [me_geom_pkg::ADDR_W-1:0]   cur_base_i,
    input  wire [me_geom_pkg::ADDR_W-1:0]   ref_base_i,
    input  wire me_geom_pkg::cur_row_t      cur_data_i,
    input  wire me_geom_pkg::ref_row_t      ref_data_i,
    output logic [me_geom_pkg::ADDR_W-1:0]  cur_addr_o,
    output logic [me_geom_pkg::ADDR_W-1:0]  ref_addr_o,
    output logic                            mem_en_o,
    output logic                            busy_o,
    output logic                            calc_o,
    me_load_if.ctrl                         load
);

    import me_geom_pkg::*;
    import me_ctrl_pkg::*;

    fetch_state_t      state_q;
    logic [ROW_W-1:0]  cnt_q;
    logic [ADDR_W-1:0] cur_base_q;
    logic [ADDR_W-1:0] ref_base_q;
    logic              rd_valid_q;
    logic [ROW_W-1:0]  rd_row_q;
    logic              last_load;

    assign mem_en_o   = (state_q == ST_FETCH);
    assign busy_o     = (state_q != ST_IDLE);
    assign cur_addr_o = cur_base_q + ADDR_W'(cnt_q);
    assign ref_addr_o = ref_base_q + ADDR_W'(cnt_q);
    assign last_load  = load.load_valid && (&load.row);

    // The counter walks the rows in FETCH and the pipeline tail in CALC.
    // Two SAD stages plus two compare stages give four cycles in CALC.
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    cnt_q <= '0;
                    if (start_i)
                        state_q <= ST_FETCH;
                end
                ST_FETCH:
                begin
                    cnt_q <= cnt_q + 1'b1;
                    if (&cnt_q)
                        state_q <= ST_LAND;
                end
                ST_LAND:
                begin
                    cnt_q <= '0;
                    if (last_load)
                        state_q <= ST_CALC;
                end
                ST_CALC:
                begin
                    cnt_q <= cnt_q + 1'b1;
                    if (&cnt_q)
                        state_q <= ST_IDLE;
                end
                default:
                begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            rd_valid_q      <= 1'b0;
            load.load_valid <= 1'b0;
            calc_o          <= 1'b0;
        end
        else
        begin
            rd_valid_q      <= mem_en_o;
            load.load_valid <= rd_valid_q;
            calc_o          <= last_load;
        end
    end

    // Memory words are registered here before they reach the buffers.
    // The row tag follows one cycle behind its address.
    always_ff @(posedge clk)
    begin
        if ((state_q == ST_IDLE) && start_i)
        begin
            cur_base_q <= cur_base_i;
            ref_base_q <= ref_base_i;
        end
        rd_row_q     <= cnt_q;
        load.row     <= rd_row_q;
        load.cur_row <= cur_data_i;
        load.ref_row <= ref_data_i;
    end

    a_no_load_idle: assert property (@(posedge clk) disable iff (rst_i)
        (state_q == ST_IDLE) |-> !load.load_valid);

endmodule

`default_nettype wire

//--- me_geom_pkg.sv
`default_nettype none

package me_geom_pkg;

    localparam int BLK_EDGE = 4;
    localparam int PIX_W    = 8;
    localparam int NUM_CAND = 8;
    localparam int WIN_W    = BLK_EDGE + NUM_CAND - 1;

    // The largest SAD is 16 * 255 = 4080, which fits in 12 bits.
    localparam int SAD_W    = 12;
    localparam int IDX_W    = 3;
    localparam int ADDR_W   = 16;

    // Pixel 0 of a row sits in the least significant byte.
    typedef logic [BLK_EDGE-1:0][PIX_W-1:0] cur_row_t;
    typedef logic [WIN_W-1:0][PIX_W-1:0]    ref_row_t;

    typedef cur_row_t [BLK_EDGE-1:0] cur_block_t;
    typedef ref_row_t [BLK_EDGE-1:0] ref_window_t;

    // One SAD per horizontal candidate offset.
    typedef logic [NUM_CAND-1:0][SAD_W-1:0] sad_vec_t;

endpackage

`default_nettype wire

//--- me_load_if.sv
`timescale 1ns/1ps
`default_nettype none

interface me_load_if;

    import me_geom_pkg::*;
    import me_ctrl_pkg::*;

    logic             load_valid;
    logic [ROW_W-1:0] row;
    cur_row_t         cur_row;
    ref_row_t         ref_row;

    modport ctrl (output load_valid, output row, output cur_row, output ref_row);

    modport sink (input load_valid, input row, input cur_row, input ref_row);

endinterface

`default_nettype wire

//--- me_min_tree.sv
`timescale 1ns/1ps
`default_nettype none

module me_min_tree (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire me_geom_pkg::sad_vec_t      sad_vec_i,
    input  wire                             sad_valid_i,
    output logic [me_geom_pkg::SAD_W-1:0]   best_sad_o,
    output logic [me_geom_pkg::IDX_W-1:0]   best_idx_o,
    output logic                            done_o
);

    import me_geom_pkg::*;

    logic [SAD_W-1:0] pair_sad_d [NUM_CAND/2];
    logic [IDX_W-1:0] pair_idx_d [NUM_CAND/2];
    logic [SAD_W-1:0] pair_sad_q [NUM_CAND/2];
    logic [IDX_W-1:0] pair_idx_q [NUM_CAND/2];
    logic             pair_valid_q;
    logic [SAD_W-1:0] lo_sad;
    logic [IDX_W-1:0] lo_idx;
    logic [SAD_W-1:0] hi_sad;
    logic [IDX_W-1:0] hi_idx;
    logic [SAD_W-1:0] fin_sad;
    logic [IDX_W-1:0] fin_idx;

    // The odd candidate only wins when it is strictly smaller.
    always_comb
    begin
        for (int k = 0; k < NUM_CAND / 2; k++)
        begin
            if (sad_vec_i[2*k+1] < sad_vec_i[2*k])
            begin
                pair_sad_d[k] = sad_vec_i[2*k+1];
                pair_idx_d[k] = IDX_W'(2*k+1);
            end
            else
            begin
                pair_sad_d[k] = sad_vec_i[2*k];
                pair_idx_d[k] = IDX_W'(2*k);
            end
        end
    end

    always_comb
    begin
        lo_sad  = (pair_sad_q[1] < pair_sad_q[0]) ? pair_sad_q[1] : pair_sad_q[0];
        lo_idx  = (pair_sad_q[1] < pair_sad_q[0]) ? pair_idx_q[1] : pair_idx_q[0];
        hi_sad  = (pair_sad_q[3] < pair_sad_q[2]) ? pair_sad_q[3] : pair_sad_q[2];
        hi_idx  = (pair_sad_q[3] < pair_sad_q[2]) ? pair_idx_q[3] : pair_idx_q[2];
        fin_sad = (hi_sad < lo_sad) ? hi_sad : lo_sad;
        fin_idx = (hi_sad < lo_sad) ? hi_idx : lo_idx;
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            pair_valid_q <= 1'b0;
            done_o       <= 1'b0;
        end
        else
        begin
            pair_valid_q <= sad_valid_i;
            done_o       <= pair_valid_q;
        end
    end

    // The result stays put between runs.
    always_ff @(posedge clk)
    begin
        if (sad_valid_i)
        begin
            pair_sad_q <= pair_sad_d;
            pair_idx_q <= pair_idx_d;
        end
        if (pair_valid_q)
        begin
            best_sad_o <= fin_sad;
            best_idx_o <= fin_idx;
        end
    end

    a_idx_range: assert property (@(posedge clk) disable iff (rst_i)
        done_o |-> (!$isunknown(best_idx_o) && (int'(best_idx_o) < NUM_CAND)));

endmodule

`default_nettype wire

//--- me_ref_window.sv
`timescale 1ns/1ps
`default_nettype none

module me_ref_window (
    input  wire                       clk,
    input  wire                       rst_i,
    me_load_if.sink                   load,
    output me_geom_pkg::ref_window_t  ref_win_o
);

    // Each row holds eleven pixels, enough for all eight horizontal offsets.
    // The SAD array takes candidate c as pixels c to c + 3 of every row.
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            ref_win_o <= '0;
        end
        else if (load.load_valid)
        begin
            ref_win_o[load.row] <= load.ref_row;
        end
    end

endmodule

`default_nettype wire

//--- me_sad_array.sv
`timescale 1ns/1ps
`default_nettype none

module me_sad_array (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire                       calc_i,
    input  wire me_geom_pkg::cur_block_t  cur_blk_i,
    input  wire me_geom_pkg::ref_window_t ref_win_i,
    output me_geom_pkg::sad_vec_t     sad_vec_o,
    output logic                      sad_valid_o
);

    import me_geom_pkg::*;

    sad_vec_t row_sad_d [BLK_EDGE];
    sad_vec_t row_sad_q [BLK_EDGE];
    sad_vec_t sad_sum_d;
    logic     valid_q;

    function automatic logic [PIX_W-1:0] abs_diff(input logic [PIX_W-1:0] a,
                                                  input logic [PIX_W-1:0] b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    // Candidate c pairs current pixel p with reference pixel c + p.
    always_comb
    begin
        for (int r = 0; r < BLK_EDGE; r++)
        begin
            for (int c = 0; c < NUM_CAND; c++)
            begin
                row_sad_d[r][c] = '0;
                for (int p = 0; p < BLK_EDGE; p++)
                begin
                    row_sad_d[r][c] = row_sad_d[r][c]
                                    + SAD_W'(abs_diff(cur_blk_i[r][p], ref_win_i[r][c + p]));
                end
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < NUM_CAND; c++)
        begin
            sad_sum_d[c] = '0;
            for (int r = 0; r < BLK_EDGE; r++)
                sad_sum_d[c] = sad_sum_d[c] + row_sad_q[r][c];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            valid_q     <= 1'b0;
            sad_valid_o <= 1'b0;
        end
        else
        begin
            valid_q     <= calc_i;
            sad_valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (calc_i)
            row_sad_q <= row_sad_d;
        if (valid_q)
            sad_vec_o <= sad_sum_d;
    end

    a_sad_latency: assert property (@(posedge clk) disable iff (rst_i)
        (sad_valid_o == $past(calc_i, 2)) && (!sad_valid_o || !$isunknown(sad_vec_o)));

endmodule

`default_nettype wire

//--- me_top.sv
`timescale 1ns/1ps
`default_nettype none

module me_top (
    input  wire                            clk,
    input  wire                            rst_i,
    input  wire                            start_i,
    input  wire [me_geom_pkg::ADDR_W-1:0]  cur_base_i,
    input  wire [me_geom_pkg::ADDR_W-1:0]  ref_base_i,
    input  wire me_geom_pkg::cur_row_t     cur_data_i,
    input  wire me_geom_pkg::ref_row_t     ref_data_i,
    output wire [me_geom_pkg::ADDR_W-1:0]  cur_addr_o,
    output wire [me_geom_pkg::ADDR_W-1:0]  ref_addr_o,
    output wire                            mem_en_o,
    output wire                            busy_o,
    output wire                            done_o,
    output wire [me_geom_pkg::SAD_W-1:0]   best_sad_o,
    output wire [me_geom_pkg::IDX_W-1:0]   best_idx_o
);

    import me_geom_pkg::*;

    cur_block_t  cur_blk;
    ref_window_t ref_win;
    sad_vec_t    sad_vec;
    logic        sad_valid;
    logic        calc;

    me_load_if load_if ();

    me_fetch_ctrl i_fetch_ctrl (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .cur_base_i (cur_base_i),
        .ref_base_i (ref_base_i),
        .cur_data_i (cur_data_i),
        .ref_data_i (ref_data_i),
        .cur_addr_o (cur_addr_o),
        .ref_addr_o (ref_addr_o),
        .mem_en_o   (mem_en_o),
        .busy_o     (busy_o),
        .calc_o     (calc),
        .load       (load_if.ctrl)
    );

    me_cur_buffer i_cur_buffer (
        .clk       (clk),
        .rst_i     (rst_i),
        .load      (load_if.sink),
        .cur_blk_o (cur_blk)
    );

    me_ref_window i_ref_window (
        .clk       (clk),
        .rst_i     (rst_i),
        .load      (load_if.sink),
        .ref_win_o (ref_win)
    );

    me_sad_array i_sad_array (
        .clk         (clk),
        .rst_i       (rst_i),
        .calc_i      (calc),
        .cur_blk_i   (cur_blk),
        .ref_win_i   (ref_win),
        .sad_vec_o   (sad_vec),
        .sad_valid_o (sad_valid)
    );

    me_min_tree i_min_tree (
        .clk         (clk),
        .rst_i       (rst_i),
        .sad_vec_i   (sad_vec),
        .sad_valid_i (sad_valid),
        .best_sad_o  (best_sad_o),
        .best_idx_o  (best_idx_o),
        .done_o      (done_o)
    );

endmodule

`default_nettype wire

//--- sim.f
me_geom_pkg.sv
me_ctrl_pkg.sv
me_load_if.sv
me_fetch_ctrl.sv
me_cur_buffer.sv
me_ref_window.sv
me_sad_array.sv
me_min_tree.sv
me_top.sv
tb_me_top.sv

//--- tb_me_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_me_top;

    localparam int MEM_WORDS    = 64;
    localparam int DONE_TIMEOUT = 40;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        start_i;
    logic [15:0] cur_base_i;
    logic [15:0] ref_base_i;
    logic [31:0] cur_data_i;
    logic [87:0] ref_data_i;
    wire  [15:0] cur_addr_o;
    wire  [15:0] ref_addr_o;
    wire         mem_en_o;
    wire         busy_o;
    wire         done_o;
    wire  [11:0] best_sad_o;
    wire  [2:0]  best_idx_o;

    logic [31:0] cur_mem [MEM_WORDS];
    logic [87:0] ref_mem [MEM_WORDS];
    logic [31:0] rng_state;
    logic        rd_en_s = 1'b0;
    logic [15:0] rd_cur_addr_s;
    logic [15:0] rd_ref_addr_s;
    logic        monitor_on = 1'b0;
    logic        done_prev = 1'b0;
    logic        held_valid = 1'b0;
    logic [11:0] held_sad;
    logic [2:0]  held_idx;
    logic [15:0] exp_cur_base = '0;
    logic [15:0] exp_ref_base = '0;
    int          read_cnt = 0;
    int          done_cnt = 0;

    me_top i_me_top (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (start_i),
        .cur_base_i (cur_base_i),
        .ref_base_i (ref_base_i),
        .cur_data_i (cur_data_i),
        .ref_data_i (ref_data_i),
        .cur_addr_o (cur_addr_o),
        .ref_addr_o (ref_addr_o),
        .mem_en_o   (mem_en_o),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .best_sad_o (best_sad_o),
        .best_idx_o (best_idx_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [7:0] next_pixel();
        logic [31:0] r;
        r = next_rand();
        return r[23:16];
    endfunction

    task automatic fail_text(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] want);
        fail_text($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, want));
    endtask

    // SAD of every horizontal offset, taken straight from the memory arrays.
    task automatic best_match_model(input logic [15:0] cb, input logic [15:0] rb,
                                    output logic [11:0] sad_best, output logic [2:0] idx_best);
        int sad;
        int diff;
        sad_best = '0;
        idx_best = '0;
        for (int c = 0; c < 8; c++)
        begin
            sad = 0;
            for (int r = 0; r < 4; r++)
            begin
                for (int p = 0; p < 4; p++)
                begin
                    diff = int'(cur_mem[cb + r][8*p +: 8]) - int'(ref_mem[rb + r][8*(c+p) +: 8]);
                    sad  = sad + ((diff < 0) ? -diff : diff);
                end
            end
            // Lowest offset wins a tie.
            if ((c == 0) || (sad < int'(sad_best)))
            begin
                sad_best = 12'(sad);
                idx_best = 3'(c);
            end
        end
    endtask

    // Sample the read request mid-cycle, answer it just after the edge.
    always @(negedge clk)
    begin
        rd_en_s       = mem_en_o;
        rd_cur_addr_s = cur_addr_o;
        rd_ref_addr_s = ref_addr_o;
    end

    always @(posedge clk)
    begin
        #2;
        if (rd_en_s)
        begin
            cur_data_i = cur_mem[rd_cur_addr_s];
            ref_data_i = ref_mem[rd_ref_addr_s];
        end
    end

    always @(negedge clk)
    begin
        if (monitor_on)
        begin
            if (mem_en_o)
            begin
                assert (read_cnt < 4) else fail_text("More than four memory reads in one run.");
                assert (cur_addr_o == exp_cur_base + 16'(read_cnt))
                    else fail_value("cur_addr_o", cur_addr_o, exp_cur_base + 16'(read_cnt));
                assert (ref_addr_o == exp_ref_base + 16'(read_cnt))
                    else fail_value("ref_addr_o", ref_addr_o, exp_ref_base + 16'(read_cnt));
                read_cnt++;
            end
            if (done_o)
            begin
                assert (!done_prev) else fail_text("done_o stayed high for two cycles.");
                done_cnt++;
                held_valid = 1'b1;
                held_sad   = best_sad_o;
                held_idx   = best_idx_o;
            end
            else if (held_valid)
            begin
                assert (best_sad_o == held_sad) else fail_value("best_sad_o", best_sad_o, held_sad);
                assert (best_idx_o == held_idx) else fail_value("best_idx_o", best_idx_o, held_idx);
            end
            done_prev = done_o;
        end
    end

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            assert (!mem_en_o && !busy_o && !done_o)
                else fail_text("The engine was active while it should have been idle.");
        end
    endtask

    task automatic run_search(input logic [15:0] cb, input logic [15:0] rb, input bit extra_start);
        logic [11:0] want_sad;
        logic [2:0]  want_idx;
        int          waited;
        int          done_before;
        best_match_model(cb, rb, want_sad, want_idx);
        @(posedge clk);
        #2;
        assert (!busy_o) else fail_value("busy_o", busy_o, 0);
        exp_cur_base = cb;
        exp_ref_base = rb;
        read_cnt     = 0;
        done_before  = done_cnt;
        start_i      = 1'b1;
        cur_base_i   = cb;
        ref_base_i   = rb;
        @(posedge clk);
        #2;
        start_i    = 1'b0;
        cur_base_i = 16'(next_rand() % 61);
        ref_base_i = 16'(next_rand() % 61);
        assert (busy_o) else fail_value("busy_o", busy_o, 1);
        if (extra_start)
        begin
            @(posedge clk);
            #2;
            start_i = 1'b1;
            @(posedge clk);
            #2;
            start_i = 1'b0;
        end
        waited = 0;
        @(negedge clk);
        while (!done_o)
        begin
            if (waited >= DONE_TIMEOUT)
                fail_text("Timed out waiting for done_o.");
            @(negedge clk);
            waited++;
        end
        assert (best_sad_o == want_sad) else fail_value("best_sad_o", best_sad_o, want_sad);
        assert (best_idx_o == want_idx) else fail_value("best_idx_o", best_idx_o, want_idx);
        assert (!busy_o) else fail_value("busy_o", busy_o, 0);
        @(posedge clk);
        #2;
        assert (done_cnt == done_before + 1)
            else fail_value("done_o pulse count", done_cnt, done_before + 1);
        assert (read_cnt == 4) else fail_value("mem_en_o read count", read_cnt, 4);
    endtask

    // Each reference row is the block row shifted right by one pixel and repeated,
    // so offsets 1 and 5 both match exactly while offset 0 cannot.
    task automatic craft_tie_rows(input logic [15:0] cb, input logic [15:0] rb);
        logic [7:0] pix [4];
        for (int r = 0; r < 4; r++)
        begin
            for (int p = 0; p < 4; p++)
                pix[p] = next_pixel();
            cur_mem[cb + r] = {pix[3], pix[2], pix[1], pix[0]};
            ref_mem[rb + r][7:0] = pix[0] ^ 8'h80;
            for (int k = 1; k < 11; k++)
                ref_mem[rb + r][8*k +: 8] = pix[(k - 1) % 4];
        end
    endtask

    initial
    begin
        int done_before;
        rst_i      = 1'b1;
        start_i    = 1'b0;
        cur_base_i = '0;
        ref_base_i = '0;
        cur_data_i = '0;
        ref_data_i = '0;
        rng_state  = 32'h61e52211;
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            for (int p = 0; p < 4; p++)
                cur_mem[a][8*p +: 8] = next_pixel();
            for (int p = 0; p < 11; p++)
                ref_mem[a][8*p +: 8] = next_pixel();
        end
        repeat (4) @(posedge clk);
        #2;
        rst_i      = 1'b0;
        monitor_on = 1'b1;

        expect_quiet(10);

        repeat (40)
            run_search(16'(next_rand() % 61), 16'(next_rand() % 61), 1'b0);

        done_before = done_cnt;
        run_search(16'd5, 16'd33, 1'b1);
        expect_quiet(16);
        assert (done_cnt == done_before + 1)
            else fail_value("done_o pulse count", done_cnt, done_before + 1);
        assert (read_cnt == 4) else fail_value("mem_en_o read count", read_cnt, 4);

        craft_tie_rows(16'd20, 16'd40);
        run_search(16'd20, 16'd40, 1'b0);
        assert (best_idx_o == 3'd1) else fail_value("best_idx_o", best_idx_o, 1);
        assert (best_sad_o == 12'd0) else fail_value("best_sad_o", best_sad_o, 0);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
